// ==== include/core_macros.svh ====
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// datapath sizes
`define CORE_XLEN     32
`define CORE_NREGS    32
`define CORE_RESET_PC 32'h0

// rv32i major opcodes that the core handles
`define CORE_OP_REG    7'b0110011
`define CORE_OP_IMM    7'b0010011
`define CORE_OP_LUI    7'b0110111
`define CORE_OP_LOAD   7'b0000011
`define CORE_OP_STORE  7'b0100011
`define CORE_OP_SYSTEM 7'b1110011 // ebreak only

`endif

// ==== design/core_pkg.sv ====
`default_nettype none

`include "core_macros.svh"

package core_pkg;

  typedef logic [`CORE_XLEN-1:0] word_t;
  typedef logic [$clog2(`CORE_NREGS)-1:0] reg_idx_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_PASSB // lui
  } alu_op_e;

  typedef enum logic [1:0] {
    MEM_NONE,
    MEM_LOAD,
    MEM_STORE
  } mem_kind_e;

  typedef struct packed {
    word_t pc;
    word_t instr;
  } fetch_pkt_t;

  typedef struct packed {
    alu_op_e   alu_op;
    word_t     op_a;
    word_t     op_b;
    word_t     sdata; // rs2 for sw
    reg_idx_t  rd;
    logic      reg_en;
    mem_kind_e mem_kind;
    logic      ebreak;
  } dec_pkt_t;

  typedef struct packed {
    word_t     result; // alu value or memory address
    word_t     sdata;
    reg_idx_t  rd;
    logic      reg_en;
    mem_kind_e mem_kind;
    logic      ebreak;
  } exe_pkt_t;

  typedef struct packed {
    reg_idx_t rd;
    word_t    data;
    logic     en;
  } wb_pkt_t;

  typedef struct packed {
    word_t      addr;
    word_t      wdata;
    logic [3:0] wstrb;
    logic       we;
  } mem_req_t;

  typedef struct packed {
    word_t rdata;
  } mem_rsp_t;

endpackage

`default_nettype wire

// ==== design/reg_file.sv ====
`default_nettype none

`include "core_macros.svh"

module reg_file (
  input  logic               clk,
  input  logic               rst,
  input  core_pkg::reg_idx_t rs1_i,
  input  core_pkg::reg_idx_t rs2_i,
  output core_pkg::word_t    rdata1_o,
  output core_pkg::word_t    rdata2_o,
  input  core_pkg::wb_pkt_t  wb_i
);

  // x0 has no storage
  logic [`CORE_XLEN-1:0] regs [1:`CORE_NREGS-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < `CORE_NREGS; i++)
        regs[i] <= '0;
    end else if (wb_i.en && wb_i.rd != '0) begin
      regs[wb_i.rd] <= wb_i.data;
    end
  end

  assign rdata1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rdata2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

// ==== design/fetch_unit.sv ====
`default_nettype none

`include "core_macros.svh"

module fetch_unit (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 retire_i,
  input  logic                 halt_i,
  output core_pkg::mem_req_t   req_o,
  output logic                 req_valid_o,
  input  logic                 req_ready_i,
  input  core_pkg::mem_rsp_t   rsp_i,
  input  logic                 rsp_valid_i,
  output core_pkg::fetch_pkt_t pkt_o,
  output logic                 pkt_valid_o,
  input  logic                 pkt_ready_i,
  output core_pkg::word_t      pc_o
);
  import core_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_REQ, S_WAIT, S_HAND} state_e;

  state_e state_q;
  word_t  pc_q;
  word_t  instr_q;
  logic   boot_q; // first fetch after reset

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= S_IDLE;
      pc_q    <= `CORE_RESET_PC;
      boot_q  <= 1'b1;
    end else begin
      if (retire_i)
        pc_q <= pc_q + 32'd4;
      case (state_q)
        S_IDLE: begin
          if ((boot_q || retire_i) && !halt_i) begin // halted core stays here
            state_q <= S_REQ;
            boot_q  <= 1'b0;
          end
        end
        S_REQ:  if (req_ready_i) state_q <= S_WAIT;
        S_WAIT: if (rsp_valid_i) state_q <= S_HAND;
        S_HAND: if (pkt_ready_i) state_q <= S_IDLE;
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == S_WAIT && rsp_valid_i)
      instr_q <= rsp_i.rdata;
  end

  // read-only port
  assign req_o.addr  = pc_q;
  assign req_o.wdata = '0;
  assign req_o.wstrb = '0;
  assign req_o.we    = 1'b0;
  assign req_valid_o = (state_q == S_REQ);

  assign pkt_o.pc    = pc_q;
  assign pkt_o.instr = instr_q;
  assign pkt_valid_o = (state_q == S_HAND);
  assign pc_o        = pc_q;

endmodule

`default_nettype wire

// ==== design/decode_unit.sv ====
`default_nettype none

`include "core_macros.svh"

module decode_unit (
  input  logic                 clk,
  input  logic                 rst,
  input  core_pkg::fetch_pkt_t pkt_i,
  input  logic                 pkt_valid_i,
  output logic                 pkt_ready_o,
  input  core_pkg::wb_pkt_t    wb_i,
  output core_pkg::dec_pkt_t   pkt_o,
  output logic                 pkt_valid_o,
  input  logic                 pkt_ready_i
);
  import core_pkg::*;

  word_t      instr;
  logic [6:0] opcode;
  logic [2:0] funct3;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_u;
  word_t      rdata1;
  word_t      rdata2;
  alu_op_e    alu_op;
  dec_pkt_t   dec_d;
  dec_pkt_t   dec_q;
  logic       valid_q;

  assign instr  = pkt_i.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign imm_i  = {{20{instr[31]}}, instr[31:20]};
  assign imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_u  = {instr[31:12], 12'b0};

  reg_file u_reg_file (
    .clk      (clk),
    .rst      (rst),
    .rs1_i    (instr[19:15]),
    .rs2_i    (instr[24:20]),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2),
    .wb_i     (wb_i)
  );

  always_comb begin
    case (funct3)
      3'b000:  alu_op = (opcode == `CORE_OP_REG && instr[30]) ? ALU_SUB : ALU_ADD;
      3'b001:  alu_op = ALU_SLL;
      3'b010:  alu_op = ALU_SLT;
      3'b011:  alu_op = ALU_SLTU;
      3'b100:  alu_op = ALU_XOR;
      3'b101:  alu_op = instr[30] ? ALU_SRA : ALU_SRL; // srai carries bit 30 too
      3'b110:  alu_op = ALU_OR;
      default: alu_op = ALU_AND;
    endcase
  end

  always_comb begin
    dec_d          = '0; // unknown opcodes become a nop
    dec_d.alu_op   = alu_op;
    dec_d.op_a     = rdata1;
    dec_d.op_b     = rdata2;
    dec_d.sdata    = rdata2;
    dec_d.rd       = instr[11:7];
    dec_d.mem_kind = MEM_NONE;
    case (opcode)
      `CORE_OP_REG: dec_d.reg_en = 1'b1;
      `CORE_OP_IMM: begin
        dec_d.op_b   = imm_i;
        dec_d.reg_en = 1'b1;
      end
      `CORE_OP_LUI: begin
        dec_d.alu_op = ALU_PASSB;
        dec_d.op_b   = imm_u;
        dec_d.reg_en = 1'b1;
      end
      `CORE_OP_LOAD: begin
        dec_d.alu_op   = ALU_ADD;
        dec_d.op_b     = imm_i;
        dec_d.reg_en   = 1'b1;
        dec_d.mem_kind = MEM_LOAD;
      end
      `CORE_OP_STORE: begin
        dec_d.alu_op   = ALU_ADD;
        dec_d.op_b     = imm_s;
        dec_d.mem_kind = MEM_STORE;
      end
      `CORE_OP_SYSTEM: dec_d.ebreak = instr[20]; // ecall is ignored
      default: ;
    endcase
  end

  assign pkt_ready_o = !valid_q || pkt_ready_i;

  always_ff @(posedge clk) begin
    if (rst)
      valid_q <= 1'b0;
    else if (pkt_ready_o)
      valid_q <= pkt_valid_i;
  end

  always_ff @(posedge clk) begin
    if (pkt_valid_i && pkt_ready_o)
      dec_q <= dec_d;
  end

  assign pkt_o       = dec_q;
  assign pkt_valid_o = valid_q;

endmodule

`default_nettype wire

// ==== design/exec_unit.sv ====
`default_nettype none

module exec_unit (
  input  logic               clk,
  input  logic               rst,
  input  core_pkg::dec_pkt_t pkt_i,
  input  logic               pkt_valid_i,
  output logic               pkt_ready_o,
  output core_pkg::exe_pkt_t pkt_o,
  output logic               pkt_valid_o,
  input  logic               pkt_ready_i
);
  import core_pkg::*;

  word_t      a;
  word_t      b;
  logic [4:0] shamt;
  word_t      result;
  exe_pkt_t   exe_q;
  logic       valid_q;

  assign a     = pkt_i.op_a;
  assign b     = pkt_i.op_b;
  assign shamt = b[4:0];

  always_comb begin
    case (pkt_i.alu_op)
      ALU_ADD:   result = a + b;
      ALU_SUB:   result = a - b;
      ALU_AND:   result = a & b;
      ALU_OR:    result = a | b;
      ALU_XOR:   result = a ^ b;
      ALU_SLL:   result = a << shamt;
      ALU_SRL:   result = a >> shamt;
      ALU_SRA:   result = $signed(a) >>> shamt;
      ALU_SLT:   result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      ALU_SLTU:  result = (a < b) ? 32'd1 : 32'd0;
      ALU_PASSB: result = b;
      default:   result = '0;
    endcase
  end

  assign pkt_ready_o = !valid_q || pkt_ready_i;

  always_ff @(posedge clk) begin
    if (rst)
      valid_q <= 1'b0;
    else if (pkt_ready_o)
      valid_q <= pkt_valid_i;
  end

  always_ff @(posedge clk) begin
    if (pkt_valid_i && pkt_ready_o) begin
      exe_q.result   <= result;
      exe_q.sdata    <= pkt_i.sdata;
      exe_q.rd       <= pkt_i.rd;
      exe_q.reg_en   <= pkt_i.reg_en;
      exe_q.mem_kind <= pkt_i.mem_kind;
      exe_q.ebreak   <= pkt_i.ebreak;
    end
  end

  assign pkt_o       = exe_q;
  assign pkt_valid_o = valid_q;

endmodule

`default_nettype wire

// ==== design/load_store_unit.sv ====
`default_nettype none

module load_store_unit (
  input  logic               clk,
  input  logic               rst,
  input  core_pkg::exe_pkt_t pkt_i,
  input  logic               pkt_valid_i,
  output logic               pkt_ready_o,
  output core_pkg::mem_req_t req_o,
  output logic               req_valid_o,
  input  logic               req_ready_i,
  input  core_pkg::mem_rsp_t rsp_i,
  input  logic               rsp_valid_i,
  output core_pkg::wb_pkt_t  wb_o,
  output logic               retire_o,
  output logic               halt_o
);
  import core_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_ALU, S_REQ, S_WAIT} state_e;

  state_e   state_q;
  exe_pkt_t pkt_q;
  logic     halt_q;

  assign pkt_ready_o = (state_q == S_IDLE);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= S_IDLE;
      halt_q  <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (pkt_valid_i) begin
            state_q <= (pkt_i.mem_kind == MEM_NONE) ? S_ALU : S_REQ;
            if (pkt_i.ebreak)
              halt_q <= 1'b1; // high by the retire cycle
          end
        end
        S_ALU:  state_q <= S_IDLE;
        S_REQ:  if (req_ready_i) state_q <= S_WAIT;
        S_WAIT: if (rsp_valid_i) state_q <= S_IDLE;
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == S_IDLE && pkt_valid_i)
      pkt_q <= pkt_i;
  end

  assign req_o.addr  = pkt_q.result;
  assign req_o.wdata = pkt_q.sdata;
  assign req_o.wstrb = 4'b1111; // word stores only
  assign req_o.we    = (pkt_q.mem_kind == MEM_STORE);
  assign req_valid_o = (state_q == S_REQ);

  assign retire_o = (state_q == S_ALU) || (state_q == S_WAIT && rsp_valid_i);

  assign wb_o.rd   = pkt_q.rd;
  assign wb_o.data = (state_q == S_WAIT) ? rsp_i.rdata : pkt_q.result;
  assign wb_o.en   = retire_o && pkt_q.reg_en && (pkt_q.mem_kind != MEM_STORE);

  assign halt_o = halt_q;

endmodule

`default_nettype wire

// ==== design/mem_arbiter.sv ====
`default_nettype none

module mem_arbiter (
  input  logic               clk,
  input  logic               rst,
  input  core_pkg::mem_req_t if_req_i,
  input  logic               if_req_valid_i,
  output logic               if_req_ready_o,
  output core_pkg::mem_rsp_t if_rsp_o,
  output logic               if_rsp_valid_o,
  input  core_pkg::mem_req_t ls_req_i,
  input  logic               ls_req_valid_i,
  output logic               ls_req_ready_o,
  output core_pkg::mem_rsp_t ls_rsp_o,
  output logic               ls_rsp_valid_o,
  output core_pkg::mem_req_t mem_req_o,
  output logic               mem_req_valid_o,
  input  logic               mem_req_ready_i,
  input  core_pkg::mem_rsp_t mem_rsp_i,
  input  logic               mem_rsp_valid_i
);
  import core_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_REQ, S_RSP} state_e;

  state_e state_q;
  logic   owner_ls_q; // 1 when load/store holds the port

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= S_IDLE;
      owner_ls_q <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (ls_req_valid_i || if_req_valid_i) begin
            state_q    <= S_REQ;
            owner_ls_q <= ls_req_valid_i; // load/store first
          end
        end
        S_REQ:  if (mem_req_ready_i) state_q <= S_RSP;
        S_RSP:  if (mem_rsp_valid_i) state_q <= S_IDLE;
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // owner keeps its request steady until ready
  assign mem_req_o       = owner_ls_q ? ls_req_i : if_req_i;
  assign mem_req_valid_o = (state_q == S_REQ);

  assign if_req_ready_o = (state_q == S_REQ) && !owner_ls_q && mem_req_ready_i;
  assign ls_req_ready_o = (state_q == S_REQ) && owner_ls_q && mem_req_ready_i;

  assign if_rsp_o       = mem_rsp_i;
  assign ls_rsp_o       = mem_rsp_i;
  assign if_rsp_valid_o = (state_q == S_RSP) && !owner_ls_q && mem_rsp_valid_i;
  assign ls_rsp_valid_o = (state_q == S_RSP) && owner_ls_q && mem_rsp_valid_i;

endmodule

`default_nettype wire

// ==== design/core_top.sv ====
`default_nettype none

module core_top (
  input  logic               clk,
  input  logic               rst,
  output core_pkg::mem_req_t mem_req_o,
  output logic               mem_req_valid_o,
  input  logic               mem_req_ready_i,
  input  core_pkg::mem_rsp_t mem_rsp_i,
  input  logic               mem_rsp_valid_i,
  output core_pkg::word_t    pc_o,
  output logic               halt_o
);
  import core_pkg::*;

  // stage handshakes
  fetch_pkt_t f_pkt;
  logic       f_valid, f_ready;
  dec_pkt_t   d_pkt;
  logic       d_valid, d_ready;
  exe_pkt_t   e_pkt;
  logic       e_valid, e_ready;

  // memory requester ports
  mem_req_t if_req, ls_req;
  logic     if_req_valid, if_req_ready, ls_req_valid, ls_req_ready;
  mem_rsp_t if_rsp, ls_rsp;
  logic     if_rsp_valid, ls_rsp_valid;

  wb_pkt_t wb;
  logic    retire;

  fetch_unit u_fetch (
    .clk (clk), .rst (rst),
    .retire_i (retire), .halt_i (halt_o),
    .req_o (if_req), .req_valid_o (if_req_valid), .req_ready_i (if_req_ready),
    .rsp_i (if_rsp), .rsp_valid_i (if_rsp_valid),
    .pkt_o (f_pkt), .pkt_valid_o (f_valid), .pkt_ready_i (f_ready),
    .pc_o (pc_o)
  );

  decode_unit u_decode (
    .clk (clk), .rst (rst),
    .pkt_i (f_pkt), .pkt_valid_i (f_valid), .pkt_ready_o (f_ready),
    .wb_i (wb),
    .pkt_o (d_pkt), .pkt_valid_o (d_valid), .pkt_ready_i (d_ready)
  );

  exec_unit u_exec (
    .clk (clk), .rst (rst),
    .pkt_i (d_pkt), .pkt_valid_i (d_valid), .pkt_ready_o (d_ready),
    .pkt_o (e_pkt), .pkt_valid_o (e_valid), .pkt_ready_i (e_ready)
  );

  load_store_unit u_lsu (
    .clk (clk), .rst (rst),
    .pkt_i (e_pkt), .pkt_valid_i (e_valid), .pkt_ready_o (e_ready),
    .req_o (ls_req), .req_valid_o (ls_req_valid), .req_ready_i (ls_req_ready),
    .rsp_i (ls_rsp), .rsp_valid_i (ls_rsp_valid),
    .wb_o (wb), .retire_o (retire), .halt_o (halt_o)
  );

  mem_arbiter u_arbiter (
    .clk (clk), .rst (rst),
    .if_req_i (if_req), .if_req_valid_i (if_req_valid), .if_req_ready_o (if_req_ready),
    .if_rsp_o (if_rsp), .if_rsp_valid_o (if_rsp_valid),
    .ls_req_i (ls_req), .ls_req_valid_i (ls_req_valid), .ls_req_ready_o (ls_req_ready),
    .ls_rsp_o (ls_rsp), .ls_rsp_valid_o (ls_rsp_valid),
    .mem_req_o (mem_req_o), .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_rsp_i (mem_rsp_i), .mem_rsp_valid_i (mem_rsp_valid_i)
  );

endmodule

`default_nettype wire

// ==== sim/sim_mem.sv ====
`default_nettype none

`include "core_macros.svh"

module sim_mem (
  input  logic               clk,
  input  logic               rst,
  input  core_pkg::mem_req_t req_i,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  output core_pkg::mem_rsp_t rsp_o,
  output logic               rsp_valid_o
);
  timeunit 1ns;
  timeprecision 1ps;
  import core_pkg::*;

  localparam int unsigned WORDS = 1024;

  word_t       mem [0:WORDS-1];
  logic [9:0]  idx;
  logic [1:0]  wait_q = 2'd0; // cycles before the next request is taken
  logic        rsp_valid_q = 1'b0;
  mem_rsp_t    rsp_q = '0;

  assign idx         = req_i.addr[11:2];
  assign req_ready_o = (wait_q == 2'd0);
  assign rsp_o       = rsp_q;
  assign rsp_valid_o = rsp_valid_q;

  always @(posedge clk) begin
    rsp_valid_q <= 1'b0;
    if (rst) begin
      wait_q <= 2'd0;
    end else if (req_valid_i && req_ready_o) begin
      wait_q      <= 2'($urandom_range(3, 0)); // delay of the next request
      rsp_valid_q <= 1'b1; // response one cycle after accept
      if (req_i.we) begin
        for (int b = 0; b < 4; b++)
          if (req_i.wstrb[b])
            mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
      end else begin
        rsp_q.rdata <= mem[idx];
      end
    end else if (req_valid_i) begin
      wait_q <= wait_q - 2'd1;
    end
  end

  // program load from the testbench
  task automatic write_word(input int unsigned widx, input word_t w);
    mem[widx] <= w;
  endtask

  function automatic word_t read_word(input int unsigned widx);
    return mem[widx];
  endfunction

endmodule

`default_nettype wire

// ==== sim/core_tb.sv ====
`default_nettype none

`include "core_macros.svh"

module core_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import core_pkg::*;

  localparam int unsigned MEM_WORDS  = 1024;
  localparam int unsigned DATA_BASE  = 32'h700; // x0..x31 dumped here
  localparam int unsigned DATA_WORDS = 34;      // plus two scratch words
  localparam logic [11:0] SCRATCH    = 12'h780;

  logic     clk;
  logic     rst;
  mem_req_t mem_req;
  logic     mem_req_valid;
  logic     mem_req_ready;
  mem_rsp_t mem_rsp;
  logic     mem_rsp_valid;
  word_t    pc;
  logic     halt;

  word_t       prog[$];
  word_t       ref_mem [0:MEM_WORDS-1];
  word_t       ref_halt_pc;
  logic        prog_ready;

  core_top DUT (
    .clk             (clk),
    .rst             (rst),
    .mem_req_o       (mem_req),
    .mem_req_valid_o (mem_req_valid),
    .mem_req_ready_i (mem_req_ready),
    .mem_rsp_i       (mem_rsp),
    .mem_rsp_valid_i (mem_rsp_valid),
    .pc_o            (pc),
    .halt_o          (halt)
  );

  sim_mem u_mem (
    .clk         (clk),
    .rst         (rst),
    .req_i       (mem_req),
    .req_valid_i (mem_req_valid),
    .req_ready_o (mem_req_ready),
    .rsp_o       (mem_rsp),
    .rsp_valid_o (mem_rsp_valid)
  );

  always #10 clk = ~clk;

  function automatic word_t r_type(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                   logic [2:0] f3, reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, `CORE_OP_REG};
  endfunction

  function automatic word_t i_type(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                   reg_idx_t rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t s_type(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `CORE_OP_STORE};
  endfunction

  function automatic word_t u_type(logic [19:0] imm, reg_idx_t rd);
    return {imm, rd, `CORE_OP_LUI};
  endfunction

  function automatic reg_idx_t rand_rd();
    return reg_idx_t'(1 + $urandom_range(28, 0)); // x30 and x31 stay fixed
  endfunction

  function automatic reg_idx_t rand_reg();
    return reg_idx_t'($urandom_range(31, 0));
  endfunction

  task automatic build_program();
    word_t      rnd;
    int         k;
    int         src;
    logic [2:0] f3;
    logic       alt;
    logic [4:0] shamt;
    logic [11:0] imm;
    for (int r = 1; r < 30; r++) begin
      rnd = $urandom();
      prog.push_back(u_type(rnd[31:12], reg_idx_t'(r)));
      rnd = $urandom();
      prog.push_back(i_type(rnd[11:0], reg_idx_t'(r), 3'd0, reg_idx_t'(r), `CORE_OP_IMM));
    end
    prog.push_back(i_type(12'd31, 5'd0, 3'd0, 5'd30, `CORE_OP_IMM));
    prog.push_back(u_type(20'h80000, 5'd31));
    // k 0..7 follow funct3, 8 is sub, 9 is sra
    for (int n = 0; n < 30; n++) begin
      k   = n % 10;
      f3  = (k < 8) ? 3'(k) : ((k == 8) ? 3'd0 : 3'd5);
      alt = (k >= 8);
      prog.push_back(r_type(alt ? 7'h20 : 7'h00, rand_reg(), rand_reg(), f3, rand_rd()));
    end
    prog.push_back(r_type(7'h00, 5'd30, rand_reg(), 3'd1, rand_rd()));
    prog.push_back(r_type(7'h00, 5'd30, 5'd31, 3'd5, rand_rd()));
    prog.push_back(r_type(7'h20, 5'd30, 5'd31, 3'd5, rand_rd()));
    for (int n = 0; n < 18; n++) begin
      k     = n % 9;
      rnd   = $urandom();
      shamt = (n < 9) ? 5'd31 : rnd[4:0];
      if (k == 1 || k == 5)
        imm = {7'h00, shamt};
      else if (k == 8)
        imm = {7'h20, shamt}; // srai
      else
        imm = rnd[31:20];
      f3 = (k == 8) ? 3'd5 : 3'(k);
      prog.push_back(i_type(imm, rand_reg(), f3, rand_rd(), `CORE_OP_IMM));
    end
    // x0 must ignore these
    prog.push_back(r_type(7'h00, 5'd6, 5'd5, 3'd0, 5'd0));
    prog.push_back(i_type(12'h7ff, 5'd0, 3'd0, 5'd0, `CORE_OP_IMM));
    src = rand_rd();
    prog.push_back(s_type(SCRATCH, reg_idx_t'(src), 5'd0));
    prog.push_back(i_type(SCRATCH, 5'd0, 3'b010, reg_idx_t'((src % 29) + 1), `CORE_OP_LOAD));
    prog.push_back(s_type(SCRATCH + 12'd4, reg_idx_t'((src % 29) + 1), 5'd0));
    for (int r = 0; r < 32; r++)
      prog.push_back(s_type(12'(DATA_BASE + 4 * r), reg_idx_t'(r), 5'd0));
    prog.push_back(32'h0010_0073); // ebreak
  endtask

  function automatic word_t alu_model(logic [2:0] f3, logic alt, word_t a, word_t b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  // ISA model of the program on ref_mem
  function automatic void run_reference();
    word_t regs [0:31];
    word_t w;
    word_t a;
    word_t b;
    word_t val;
    word_t imm_i;
    word_t imm_s;
    word_t pc_m;
    logic  en;
    logic  done;
    for (int i = 0; i < 32; i++)
      regs[i] = '0;
    pc_m = `CORE_RESET_PC;
    done = 1'b0;
    for (int step = 0; step < MEM_WORDS && !done; step++) begin
      w     = ref_mem[pc_m[11:2]];
      a     = regs[w[19:15]];
      b     = regs[w[24:20]];
      imm_i = {{20{w[31]}}, w[31:20]};
      imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
      en    = 1'b1;
      val   = '0;
      case (w[6:0])
        `CORE_OP_LUI:   val = {w[31:12], 12'h000};
        `CORE_OP_IMM:   val = alu_model(w[14:12], (w[14:12] == 3'd5) && w[30], a, imm_i);
        `CORE_OP_REG:   val = alu_model(w[14:12], w[30], a, b);
        `CORE_OP_LOAD:  val = ref_mem[(a + imm_i) >> 2];
        `CORE_OP_STORE: begin
          ref_mem[(a + imm_s) >> 2] = b;
          en = 1'b0;
        end
        default: begin
          en   = 1'b0;
          done = (w == 32'h0010_0073);
        end
      endcase
      if (en && w[11:7] != 5'd0)
        regs[w[11:7]] = val;
      if (done)
        ref_halt_pc = pc_m;
      else
        pc_m = pc_m + 32'd4;
    end
  endfunction

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      $display("sim failed");
      $fatal(1, "value mismatch");
    end
  endtask

  initial begin
    word_t fill;
    clk        = 1'b0;
    rst        = 1'b1;
    prog_ready = 1'b0;
    void'($urandom(32'he373_6b97));
    build_program();
    for (int i = 0; i < MEM_WORDS; i++) begin
      fill       = 32'h5a5a_0000 ^ (word_t'(i) << 2); // follows the byte address
      ref_mem[i] = (i < prog.size()) ? prog[i] : fill;
      u_mem.write_word(i, ref_mem[i]);
    end
    run_reference();
    prog_ready = 1'b1;
    repeat (15) @(posedge clk);
    @(negedge clk);
    check_word("halt in reset", '0, word_t'(halt));
    check_word("pc in reset", `CORE_RESET_PC, pc);
    check_word("request in reset", '0, word_t'(mem_req_valid));
    @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_word("request after reset", '0, word_t'(mem_req_valid));
    check_word("pc after reset", `CORE_RESET_PC, pc);
  end

  initial begin : compare
    int unsigned idx;
    wait (prog_ready === 1'b1 && rst === 1'b0);
    wait (halt === 1'b1);
    repeat (20) begin
      @(negedge clk);
      check_word("request after halt", '0, word_t'(mem_req_valid));
    end
    check_word("halt held", 32'd1, word_t'(halt));
    check_word("pc after ebreak", ref_halt_pc + 32'd4, pc);
    for (int i = 0; i < DATA_WORDS; i++) begin
      idx = (DATA_BASE >> 2) + i;
      check_word($sformatf("data word %0d", i), ref_mem[idx], u_mem.read_word(idx));
    end
    $display("sim passed");
    $finish;
  end

  initial begin : watchdog
    longint unsigned limit_ns;
    wait (prog_ready === 1'b1 && rst === 1'b0);
    limit_ns = longint'(prog.size()) * 20 * 20;
    #(limit_ns);
    $display("core did not halt");
    $display("sim failed");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+include
design/core_pkg.sv
design/reg_file.sv
design/fetch_unit.sv
design/decode_unit.sv
design/exec_unit.sv
design/load_store_unit.sv
design/mem_arbiter.sv
design/core_top.sv
sim/sim_mem.sv
sim/core_tb.sv
